/* logic/rd_mem_pkg.sv */
//----------------------------------------
// Memory read port types. All addresses are
// byte addresses of whole memory lines
//----------------------------------------
`default_nettype none

package rd_mem_pkg;

    // Byte address of one memory line on the read request port
    // The engine steps it by the line size in bytes, so the low bits
    // stay as the host gave them in base_addr
    typedef logic [31:0] t_addr;

endpackage

`default_nettype wire

/* logic/rd_eng_pkg.sv */
//----------------------------------------
// Engine control types. Line counts are
// 16 bits, so a run holds up to 65535 lines
//----------------------------------------
`default_nettype none

package rd_eng_pkg;

    // Line count of a run, also the sequence number of a line
    // The sequence number rides along as scoreboard meta-data
    typedef logic [15:0] t_count;

    // Control FSM states
    // ST_DONE lasts exactly one cycle and marks the end of a run
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_RUN,
        ST_DONE
    } t_seq_state;

endpackage

`default_nettype wire

/* logic/rd_engine_if.sv */
//----------------------------------------
// Scoreboard allocate and dequeue buses.
// N_ENTRIES must be a power of two
//----------------------------------------
`default_nettype none

// Slot allocation, driven by the control when it issues a read
interface sb_alloc_if #(
    parameter int N_ENTRIES   = 16,
    parameter int N_META_BITS = 16
);
    logic                         enq_en;
    logic [N_META_BITS-1:0]       enq_meta;
    logic                         not_full;
    logic [$clog2(N_ENTRIES)-1:0] enq_idx;

    modport ctrl (output enq_en, output enq_meta, input not_full, input enq_idx);
    modport sb (input enq_en, input enq_meta, output not_full, output enq_idx);
endinterface

// In-order release of the oldest line
// first and first_meta are only meaningful while not_empty is high
interface sb_deq_if #(
    parameter int N_DATA_BITS = 64,
    parameter int N_META_BITS = 16
);
    logic                   deq_en;
    logic                   not_empty;
    logic [N_DATA_BITS-1:0] first;
    logic [N_META_BITS-1:0] first_meta;

    modport sb (input deq_en, output not_empty, output first, output first_meta);
    modport ctrl (output deq_en, input not_empty);
    modport acc (input deq_en, input first);
endinterface

`default_nettype wire

/* logic/reorder_scoreboard.sv */
//----------------------------------------
// Reorder buffer. No ready on the response
// write, holds N_ENTRIES-1 lines at most
//----------------------------------------
`default_nettype none

module reorder_scoreboard #(
    parameter int N_ENTRIES   = 16,
    parameter int N_DATA_BITS = 64,
    parameter int N_META_BITS = 16
) (
    input  logic                         clk,
    input  logic                         resetb,
    sb_alloc_if.sb                       alloc,
    sb_deq_if.sb                         deq,
    input  logic                         rsp_valid,
    input  logic [$clog2(N_ENTRIES)-1:0] rsp_tag,
    input  logic [N_DATA_BITS-1:0]       rsp_data
);
    localparam int N_IDX_BITS  = $clog2(N_ENTRIES);
    localparam int N_HALF_BITS = N_DATA_BITS / 2;

    typedef logic [N_IDX_BITS-1:0]  t_idx;
    typedef logic [N_HALF_BITS-1:0] t_half;
    typedef logic [N_META_BITS-1:0] t_meta;

    // Empty when oldest equals newest, full when newest is one behind oldest
    t_idx newest;
    t_idx oldest;
    t_idx oldest_next;

    // One bit per slot, set when its response has been written
    logic [N_ENTRIES-1:0] data_valid;
    logic [N_ENTRIES-1:0] data_valid_next;

    // Line storage is half the line width and twice as deep
    // Each slot owns two words, low half at {idx, 0} and high half at {idx, 1}
    t_half data_mem [2*N_ENTRIES];
    t_meta meta_mem [N_ENTRIES];
    t_half wr_half [2];
    t_half first_half [2];

    // Both memory ports share one address, the write slot wins over the read
    t_idx ram_idx;

    assign alloc.not_full = (newest + t_idx'(1)) != oldest;
    assign alloc.enq_idx  = newest;

    // The oldest pointer moves past a line in the cycle it is dequeued
    assign oldest_next = oldest + t_idx'(deq.deq_en);

    assign wr_half[0] = rsp_data[N_HALF_BITS-1:0];
    assign wr_half[1] = rsp_data[N_DATA_BITS-1:N_HALF_BITS];
    assign deq.first  = {first_half[1], first_half[0]};

    assign ram_idx = rsp_valid ? rsp_tag : oldest_next;

    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            newest <= '0;
            oldest <= '0;
        end
        else
        begin
            if (alloc.enq_en)
            begin
                newest <= newest + t_idx'(1);
            end
            oldest <= oldest_next;
        end
    end

    // Dual-port line memory, one port per half word
    // A write occupies both ports, so the read of the oldest line waits
    // The write data goes through to the read register like a write-first RAM
    always_ff @(posedge clk)
    begin
        for (int p = 0; p < 2; p++)
        begin
            if (rsp_valid)
            begin
                data_mem[{ram_idx, 1'(p)}] <= wr_half[p];
                first_half[p] <= wr_half[p];
            end
            else
            begin
                first_half[p] <= data_mem[{ram_idx, 1'(p)}];
            end
        end
    end

    // Meta-data is known at allocation time and is written with the slot
    // It is read from the slot that will be oldest in the next cycle
    always_ff @(posedge clk)
    begin
        deq.first_meta <= meta_mem[oldest_next];
        if (alloc.enq_en)
        begin
            meta_mem[newest] <= alloc.enq_meta;
        end
    end

    always_comb
    begin
        data_valid_next = data_valid;
        // A dequeued slot is free again
        if (deq.deq_en)
        begin
            data_valid_next[oldest] = 1'b0;
        end
        // A response marks its slot as present
        if (rsp_valid)
        begin
            data_valid_next[rsp_tag] = 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            data_valid <= '0;
        end
        else
        begin
            data_valid <= data_valid_next;
        end
    end

    // not_empty comes from the registered present bits, so it rises in the
    // first cycle the read register holds the line
    // Without this, a response would show up one cycle before its data
    // A write in this cycle takes the read port, so the oldest line waits
    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            deq.not_empty <= 1'b0;
        end
        else
        begin
            deq.not_empty <= data_valid[oldest_next] && !rsp_valid;
        end
    end

endmodule

`default_nettype wire

/* logic/rd_seq_ctrl.sv */
//----------------------------------------
// Read engine control. start is ignored
// outside idle, a run always ends in done
//----------------------------------------
`default_nettype none

module rd_seq_ctrl
    import rd_mem_pkg::*;
    import rd_eng_pkg::*;
#(
    parameter int N_DATA_BITS = 64
) (
    input  logic     clk,
    input  logic     resetb,
    input  logic     start,
    input  t_addr    base_addr,
    input  t_count   num_lines,
    output logic     busy,
    output logic     done,
    output logic     rd_req,
    output t_addr    rd_addr,
    sb_alloc_if.ctrl alloc,
    sb_deq_if.ctrl   deq
);
    // Address step between two consecutive lines
    localparam t_addr LINE_BYTES = t_addr'(N_DATA_BITS / 8);

    t_seq_state state;

    // Line count and next request address, loaded at start
    t_count lines_q;
    t_addr  addr_q;

    // Requests issued and lines retired in this run
    t_count issued;
    t_count retired;
    t_count retired_next;
    logic   issue;

    // A request needs a free slot and a line still to fetch
    assign issue = (state == ST_RUN) && alloc.not_full && (issued != lines_q);

    assign retired_next = retired + t_count'(deq.deq_en);

    // Request and slot allocation happen in the same cycle
    // The issue count becomes the line's sequence number
    assign rd_req         = issue;
    assign rd_addr        = addr_q;
    assign alloc.enq_en   = issue;
    assign alloc.enq_meta = issued;

    // There is no back-pressure on the output, so every ready line leaves
    assign deq.deq_en = deq.not_empty;

    assign busy = (state == ST_RUN);
    assign done = (state == ST_DONE);

    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            state   <= ST_IDLE;
            issued  <= '0;
            retired <= '0;
        end
        else
        begin
            case (state)
                ST_IDLE:
                begin
                    if (start)
                    begin
                        state   <= ST_RUN;
                        issued  <= '0;
                        retired <= '0;
                    end
                end
                ST_RUN:
                begin
                    if (issue)
                    begin
                        issued <= issued + t_count'(1);
                    end
                    retired <= retired_next;
                    // The last line leaves in this cycle, or the run was empty
                    if (retired_next == lines_q)
                    begin
                        state <= ST_DONE;
                    end
                end
                ST_DONE:
                begin
                    state <= ST_IDLE;
                end
                default:
                begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if ((state == ST_IDLE) && start)
        begin
            lines_q <= num_lines;
            addr_q  <= base_addr;
        end
        else if (issue)
        begin
            addr_q <= addr_q + LINE_BYTES;
        end
    end

endmodule

`default_nettype wire

/* logic/rsp_accum.sv */
//----------------------------------------
// Order-sensitive checksum of the lines
// released by the scoreboard
//----------------------------------------
`default_nettype none

module rsp_accum #(
    parameter int N_DATA_BITS = 64
) (
    input  logic                   clk,
    input  logic                   resetb,
    input  logic                   clear,
    sb_deq_if.acc                  deq,
    output logic [N_DATA_BITS-1:0] sum
);
    logic [N_DATA_BITS-1:0] sum_rot;

    // Rotating before the XOR makes the result depend on line order
    assign sum_rot = {sum[N_DATA_BITS-2:0], sum[N_DATA_BITS-1]};

    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            sum <= '0;
        end
        else if (clear)
        begin
            // A new run starts from zero
            sum <= '0;
        end
        else if (deq.deq_en)
        begin
            sum <= sum_rot ^ deq.first;
        end
    end

endmodule

`default_nettype wire

/* logic/rd_engine_top.sv */
//----------------------------------------
// Ordered read engine. N_ENTRIES is a power
// of two, N_DATA_BITS a multiple of 8
//----------------------------------------
`default_nettype none

module rd_engine_top
    import rd_mem_pkg::*;
    import rd_eng_pkg::*;
#(
    parameter int N_ENTRIES   = 16,
    parameter int N_DATA_BITS = 64
) (
    input  logic                         clk,
    input  logic                         resetb,
    input  logic                         start,
    input  t_addr                        base_addr,
    input  t_count                       num_lines,
    output logic                         busy,
    output logic                         done,
    output logic                         rd_req,
    output t_addr                        rd_addr,
    output logic [$clog2(N_ENTRIES)-1:0] rd_tag,
    input  logic                         rsp_valid,
    input  logic [$clog2(N_ENTRIES)-1:0] rsp_tag,
    input  logic [N_DATA_BITS-1:0]       rsp_data,
    output logic                         out_valid,
    output logic [N_DATA_BITS-1:0]       out_data,
    output t_count                       out_seq,
    output logic [N_DATA_BITS-1:0]       sum
);
    // Sequence numbers are the scoreboard's meta-data
    sb_alloc_if #(.N_ENTRIES(N_ENTRIES), .N_META_BITS($bits(t_count))) alloc_if ();
    sb_deq_if #(.N_DATA_BITS(N_DATA_BITS), .N_META_BITS($bits(t_count))) deq_if ();

    // The control accepts start only when idle, which is neither busy nor done
    logic start_accept;
    assign start_accept = start && !busy && !done;

    // The request tag is the slot taken in the same cycle
    assign rd_tag    = alloc_if.enq_idx;
    assign out_valid = deq_if.not_empty;
    assign out_data  = deq_if.first;
    assign out_seq   = deq_if.first_meta;

    reorder_scoreboard #(
        .N_ENTRIES   (N_ENTRIES),
        .N_DATA_BITS (N_DATA_BITS),
        .N_META_BITS ($bits(t_count))
    ) u_sb (
        .clk       (clk),
        .resetb    (resetb),
        .alloc     (alloc_if.sb),
        .deq       (deq_if.sb),
        .rsp_valid (rsp_valid),
        .rsp_tag   (rsp_tag),
        .rsp_data  (rsp_data)
    );

    rd_seq_ctrl #(
        .N_DATA_BITS (N_DATA_BITS)
    ) u_ctrl (
        .clk       (clk),
        .resetb    (resetb),
        .start     (start),
        .base_addr (base_addr),
        .num_lines (num_lines),
        .busy      (busy),
        .done      (done),
        .rd_req    (rd_req),
        .rd_addr   (rd_addr),
        .alloc     (alloc_if.ctrl),
        .deq       (deq_if.ctrl)
    );

    rsp_accum #(
        .N_DATA_BITS (N_DATA_BITS)
    ) u_accum (
        .clk    (clk),
        .resetb (resetb),
        .clear  (start_accept),
        .deq    (deq_if.acc),
        .sum    (sum)
    );

endmodule

`default_nettype wire

/* verification/reorder_scoreboard_checker.sv */
//----------------------------------------
// Scoreboard protocol assertions, bound to
// every reorder_scoreboard instance
//----------------------------------------
`default_nettype none

module reorder_scoreboard_checker #(
    parameter int N_ENTRIES = 16
) (
    input  logic                         clk,
    input  logic                         resetb,
    input  logic                         enq_en,
    input  logic                         not_full,
    input  logic                         deq_en,
    input  logic                         not_empty,
    input  logic                         rsp_valid,
    input  logic [$clog2(N_ENTRIES)-1:0] rsp_tag,
    input  logic [N_ENTRIES-1:0]         data_valid
);
    // A slot is only taken while one is free
    a_enq_not_full: assert property (@(posedge clk) disable iff (!resetb)
        enq_en |-> not_full)
        else $error("enq_en while the scoreboard is full");

    // Only a present oldest line can be released
    a_deq_not_empty: assert property (@(posedge clk) disable iff (!resetb)
        deq_en |-> not_empty)
        else $error("deq_en while the scoreboard is empty");

    // Each allocated slot gets exactly one response
    a_rsp_once: assert property (@(posedge clk) disable iff (!resetb)
        rsp_valid |-> !data_valid[rsp_tag])
        else $error("response written to a slot that already holds data");

    // A write takes both memory ports, so the read side must wait a cycle
    a_write_blocks_read: assert property (@(posedge clk) disable iff (!resetb)
        rsp_valid |=> !not_empty)
        else $error("not_empty high in the cycle after a response write");

endmodule

bind reorder_scoreboard reorder_scoreboard_checker #(
    .N_ENTRIES (N_ENTRIES)
) u_sb_chk (
    .clk        (clk),
    .resetb     (resetb),
    .enq_en     (alloc.enq_en),
    .not_full   (alloc.not_full),
    .deq_en     (deq.deq_en),
    .not_empty  (deq.not_empty),
    .rsp_valid  (rsp_valid),
    .rsp_tag    (rsp_tag),
    .data_valid (data_valid)
);

`default_nettype wire

/* verification/tb_rd_engine.sv */
//----------------------------------------
// Read engine testbench with a random-order
// memory model. Built for 64-bit lines only
//----------------------------------------
`default_nettype none

module tb_rd_engine
    import rd_mem_pkg::*;
    import rd_eng_pkg::*;
();
    localparam int N_ENTRIES   = 8;
    localparam int N_DATA_BITS = 64;
    localparam int N_TAG_BITS  = $clog2(N_ENTRIES);
    localparam int N_ROWS      = 6;

    typedef logic [N_DATA_BITS-1:0] t_line;

    // One run of the engine, slow rows answer about one cycle in eight
    typedef struct packed {
        t_addr  base;
        t_count lines;
        logic   slow;
    } t_row;

    string row_name [N_ROWS] = '{"zero_lines", "short_run", "full_window",
                                 "slow_20", "high_addr", "rerun_clear"};
    t_row rows [N_ROWS] = '{
        '{32'h0000_1000, 16'd0,  1'b0},
        '{32'h0000_2000, 16'd5,  1'b0},
        '{32'h0001_0008, 16'd12, 1'b0},
        '{32'h0008_0000, 16'd20, 1'b1},
        '{32'hFFFF_FFC0, 16'd9,  1'b0},
        '{32'h0000_2000, 16'd5,  1'b0}
    };

    logic                  clk = 1'b0;
    logic                  resetb;
    logic                  start;
    t_addr                 base_addr;
    t_count                num_lines;
    logic                  busy;
    logic                  done;
    logic                  rd_req;
    t_addr                 rd_addr;
    logic [N_TAG_BITS-1:0] rd_tag;
    logic                  rsp_valid;
    logic [N_TAG_BITS-1:0] rsp_tag;
    t_line                 rsp_data;
    logic                  out_valid;
    t_line                 out_data;
    t_count                out_seq;
    t_line                 sum;

    integer seed = 32'h6ecc;
    int     checks = 0;
    int     value_errors = 0;
    int     rule_errors = 0;
    int     cycles = 0;
    int     cycle_limit = 0;

    // Expected state of the row that is running
    string  cur_name = "reset";
    t_addr  cur_base;
    int     cur_lines;
    logic   cur_slow;
    int     issued;
    int     retired;
    t_line  exp_sum;
    logic   done_seen;
    logic   prev_done = 1'b0;
    logic   last_out = 1'b0;

    // Requests the memory model has not answered yet
    logic [N_TAG_BITS-1:0] pend_tag [$];
    t_addr                 pend_addr [$];

    rd_engine_top #(
        .N_ENTRIES   (N_ENTRIES),
        .N_DATA_BITS (N_DATA_BITS)
    ) dut0 (
        .clk       (clk),
        .resetb    (resetb),
        .start     (start),
        .base_addr (base_addr),
        .num_lines (num_lines),
        .busy      (busy),
        .done      (done),
        .rd_req    (rd_req),
        .rd_addr   (rd_addr),
        .rd_tag    (rd_tag),
        .rsp_valid (rsp_valid),
        .rsp_tag   (rsp_tag),
        .rsp_data  (rsp_data),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_seq   (out_seq),
        .sum       (sum)
    );

    always #2 clk = ~clk;

    // Stops a run that never reaches done
    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if ((cycle_limit > 0) && (cycles > cycle_limit))
        begin
            $display("Timeout after %0d cycles, the engine never finished %s", cycles, cur_name);
            $display("TEST FAIL");
            $finish;
        end
    end

    // Memory content, the inverted address above the address itself
    function automatic t_line mem_line(input t_addr addr);
        return {~addr, addr};
    endfunction

    task automatic check_equal(input string what, input t_line exp, input t_line act);
        checks++;
        assert (act === exp)
        else
        begin
            value_errors++;
            $display("FAILED %s %s expected %h actual %h", cur_name, what, exp, act);
        end
    endtask

    task automatic check_rule(input logic ok, input string msg);
        checks++;
        assert (ok)
        else
        begin
            rule_errors++;
            $display("ERROR in %s: %s", cur_name, msg);
        end
    endtask

    // One clock cycle: check the outputs, answer a request, log new requests
    task automatic step_cycle();
        t_addr k_addr;
        t_line exp_line;
        int    ret_before;
        int    r;
        int    rate_mask;
        int    pick;
        @(negedge clk);
        ret_before = retired;
        // rsp_valid still holds the value the last rising edge took in
        check_rule(!(rsp_valid && out_valid), "out_valid high right after a response write");
        check_rule(!(done && prev_done), "done stayed high for more than one cycle");
        if (out_valid)
        begin
            // Line k must carry sequence number k and the data of its address
            k_addr   = cur_base + t_addr'(retired * 8);
            exp_line = mem_line(k_addr);
            check_rule(retired < issued, "a line came out before it was requested");
            check_equal("out_seq", t_line'(retired), t_line'(out_seq));
            check_equal("out_data", exp_line, out_data);
            exp_sum = {exp_sum[N_DATA_BITS-2:0], exp_sum[N_DATA_BITS-1]} ^ exp_line;
            retired++;
        end
        if (done)
        begin
            check_rule(!busy, "busy still high in the done cycle");
            check_rule(last_out || (cur_lines == 0), "done did not follow the last line");
            check_equal("issued lines", t_line'(cur_lines), t_line'(issued));
            check_equal("retired lines", t_line'(cur_lines), t_line'(retired));
            check_equal("sum", exp_sum, sum);
            check_rule(pend_tag.size() == 0, "requests still unanswered at done");
            done_seen = 1'b1;
        end
        // The memory answers a random pending request, in any order
        r         = $random(seed);
        rate_mask = cur_slow ? 7 : 1;
        if ((pend_tag.size() > 0) && ((r & rate_mask) == 0))
        begin
            r         = $random(seed);
            pick      = int'($unsigned(r) % pend_tag.size());
            rsp_valid = 1'b1;
            rsp_tag   = pend_tag[pick];
            rsp_data  = mem_line(pend_addr[pick]);
            pend_tag.delete(pick);
            pend_addr.delete(pick);
        end
        else
        begin
            rsp_valid = 1'b0;
        end
        // New requests are answered from the next cycle on
        if (rd_req)
        begin
            k_addr = cur_base + t_addr'(issued * 8);
            check_rule(busy, "rd_req while the engine is not busy");
            check_equal("rd_addr", t_line'(k_addr), t_line'(rd_addr));
            issued++;
            check_rule(issued <= cur_lines, "more requests than lines");
            check_rule((issued - ret_before) <= (N_ENTRIES - 1), "too many lines outstanding");
            pend_tag.push_back(rd_tag);
            pend_addr.push_back(rd_addr);
        end
        prev_done = done;
        last_out  = out_valid;
    endtask

    // Starts one row of the table and follows it until done
    task automatic run_row(input int i);
        int steps;
        // The engine only takes start when idle, one cycle after done
        while (busy || done)
        begin
            step_cycle();
        end
        cur_name  = row_name[i];
        cur_base  = rows[i].base;
        cur_lines = int'(rows[i].lines);
        cur_slow  = rows[i].slow;
        issued    = 0;
        retired   = 0;
        exp_sum   = '0;
        done_seen = 1'b0;
        steps     = 0;
        base_addr = rows[i].base;
        num_lines = rows[i].lines;
        start     = 1'b1;
        step_cycle();
        start = 1'b0;
        check_rule(busy, "busy did not rise after start");
        check_equal("cleared sum", '0, sum);
        while (!done_seen)
        begin
            step_cycle();
            steps++;
        end
        if (cur_lines == 0)
        begin
            check_rule(steps == 1, "an empty run did not end one cycle after busy");
        end
    endtask

    initial
    begin
        int total;
        resetb    = 1'b0;
        start     = 1'b0;
        base_addr = '0;
        num_lines = '0;
        rsp_valid = 1'b0;
        rsp_tag   = '0;
        rsp_data  = '0;
        // Each line gets 40 cycles, plus room for reset and idle gaps
        total = 0;
        for (int i = 0; i < N_ROWS; i++)
        begin
            total += int'(rows[i].lines);
        end
        cycle_limit = total * 40 + 200;
        repeat (2) @(negedge clk);
        resetb = 1'b1;
        step_cycle();
        check_rule(!busy && !done && !rd_req && !out_valid, "outputs not idle after reset");
        for (int i = 0; i < N_ROWS; i++)
        begin
            run_row(i);
        end
        // Lets done drop before the run ends
        step_cycle();
        step_cycle();
        $display("Checks: %0d, value errors: %0d, rule errors: %0d",
                 checks, value_errors, rule_errors);
        if ((value_errors == 0) && (rule_errors == 0))
        begin
            $display("TEST PASS");
        end
        else
        begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
logic/rd_mem_pkg.sv
logic/rd_eng_pkg.sv
logic/rd_engine_if.sv
logic/reorder_scoreboard.sv
logic/rd_seq_ctrl.sv
logic/rsp_accum.sv
logic/rd_engine_top.sv
verification/reorder_scoreboard_checker.sv
verification/tb_rd_engine.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the read engine testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module tb_rd_engine \
    -Mdir obj_dir -o sim_rd_engine > build.log 2>&1 &&
./obj_dir/sim_rd_engine > sim.log 2>&1 ||
{ echo "Build or simulation did not complete, see build.log and sim.log"; exit 1; }

grep -q "^TEST PASS$" sim.log &&
echo "Simulation passed" ||
{ echo "Simulation failed, see sim.log"; exit 1; }
